/* flist.f */
+incdir+verilog
verilog/mcu_pkg.sv
verilog/mcu_store_cfg_if.sv
verilog/mcu_cmd_decode.sv
verilog/mcu_store_seq.sv
verilog/mcu_wr_stream.sv
verilog/mcu_store_top.sv
test/tb_mcu_store.sv

/* run_sim.sh */
#!/bin/sh
# Build the store MCU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mcu_store \
  -f flist.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log || ! grep -q "PASS: all tests" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* test/mcu_store_input.txt */
// sew lmul dw mode | base stride | count | exp_err exp_sew exp_lmul  (all hex)
// mode 2 is unit, mode 1 is strided; a count of 0 ends the list
0 0 0 2 00001000 00000000 4 0 0 0
2 1 2 1 00002000 00000010 5 0 2 1
0 3 0 2 00003000 00000000 8 0 0 3
0 3 1 2 00000000 00000000 4 1 0 0
3 0 3 2 00000000 00000000 4 1 0 0
0 4 0 1 00000000 00000000 4 1 0 0
2 5 0 1 00000000 00000000 4 1 0 0
2 6 1 1 00000100 00000004 3 0 1 5
1 7 1 2 00004000 00000000 6 0 1 7
0 7 2 1 80000000 00000040 4 0 2 1
2 0 0 2 00005000 00000000 1 0 0 6
1 2 0 1 00000010 00000008 1 0 0 1
0 2 3 2 00000000 00000000 4 1 0 0
1 5 0 1 00000000 00000000 4 1 0 0
2 3 3 2 00000000 00000000 4 1 0 0
2 3 2 2 00006000 00000000 a 0 2 3
0 5 0 1 00001000 fffffff8 6 0 0 5
1 6 1 2 00007000 00000000 7 0 1 6
3 7 0 1 00000000 00000000 4 1 0 0
1 1 3 1 abcd0000 00000100 3 0 3 3
2 2 1 2 00008000 00000000 5 0 1 1
0 0 7 2 00000000 00000000 4 1 0 0
2 1 0 1 00000000 00000000 2 0 0 7
0 0 0 0 00000000 00000000 0 0 0 0

/* test/tb_mcu_store.sv */
// Store memory control unit testbench
// Replays commands from a data file against buffer and memory-master models

`timescale 1ns/1ps
`default_nettype none

module tb_mcu_store;

  localparam int MAX_CMDS = 64;
  localparam int FIELDS   = 10;

  logic               clk;
  logic               rstn;
  logic               st_vld_i;
  logic               st_rdy_o;
  mcu_pkg::vtype_t    sew_i;
  mcu_pkg::vtype_t    lmul_i;
  mcu_pkg::vtype_t    data_width_i;
  mcu_pkg::st_mode_t  mode_i;
  mcu_pkg::addr_t     base_addr_i;
  mcu_pkg::addr_t     stride_i;
  logic               cmd_err_o;
  logic               cfg_update_o;
  mcu_pkg::vtype_t    cfg_data_sew_o;
  mcu_pkg::vtype_t    cfg_data_lmul_o;
  logic               vlane_store_valid_i = 1'b0;
  logic               sbuff_wen_o;
  logic               sbuff_ren_o;
  logic               sbuff_read_stall;
  logic               sbuff_write_done_i = 1'b0;
  logic               sbuff_read_done_i = 1'b0;
  logic               ctrl_wstart_o;
  logic               ctrl_wdone_i = 1'b0;
  logic               wr_tvalid_o;
  logic               wr_tready_i = 1'b0;
  mcu_pkg::addr_t     store_addr_o;

  logic [31:0]        cmd_mem [0:MAX_CMDS*FIELDS-1];
  int                 n_cmds = 0;
  int                 err_count = 0;
  mcu_pkg::st_mode_t  cur_mode = '0;
  mcu_pkg::addr_t     cur_base = '0;
  mcu_pkg::addr_t     cur_stride = '0;
  int                 cur_count = 0;
  // Model and monitor state
  logic [31:0]        lcg_state = 32'd62998;
  int                 wr_cnt = 0;
  int                 rd_cnt = 0;
  int                 burst_beats = 0;
  logic               burst_active = 1'b0;
  int                 beat_cnt = 0;
  int                 wstart_cnt = 0;
  mcu_pkg::addr_t     exp_addr;
  logic               in_drain = 1'b0;

  mcu_store_top mcu_store_top_inst (
    .clk (clk), .rstn (rstn), .st_vld_i (st_vld_i), .st_rdy_o (st_rdy_o),
    .sew_i (sew_i), .lmul_i (lmul_i), .data_width_i (data_width_i), .mode_i (mode_i),
    .base_addr_i (base_addr_i), .stride_i (stride_i), .cmd_err_o (cmd_err_o),
    .cfg_update_o (cfg_update_o), .cfg_data_sew_o (cfg_data_sew_o),
    .cfg_data_lmul_o (cfg_data_lmul_o), .vlane_store_valid_i (vlane_store_valid_i),
    .sbuff_wen_o (sbuff_wen_o), .sbuff_ren_o (sbuff_ren_o),
    .sbuff_read_stall_o (sbuff_read_stall), .sbuff_write_done_i (sbuff_write_done_i),
    .sbuff_read_done_i (sbuff_read_done_i), .ctrl_wstart_o (ctrl_wstart_o),
    .ctrl_wdone_i (ctrl_wdone_i), .wr_tvalid_o (wr_tvalid_o), .wr_tready_i (wr_tready_i),
    .store_addr_o (store_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Result checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    err_count++;
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_vtype(input mcu_pkg::vtype_t got, input mcu_pkg::vtype_t exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input mcu_pkg::addr_t got, input mcu_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // LCG step for back-pressure and lane valid
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  ////////////////////////////////////////////////////////////
  // Lane, buffer and memory-master models
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    lcg_state = lcg_next(lcg_state);
    // Ready low about a quarter of the time
    wr_tready_i         <= (lcg_state[17:16] != 2'b00);
    vlane_store_valid_i <= lcg_state[20] | lcg_state[21];
  end

  // Counters restart while the unit is idle
  always @(posedge clk) begin
    if (!rstn || st_rdy_o) begin
      wr_cnt = 0;
      rd_cnt = 0;
      sbuff_write_done_i <= 1'b0;
      sbuff_read_done_i  <= 1'b0;
    end else begin
      if (sbuff_wen_o) wr_cnt++;
      if (sbuff_ren_o) rd_cnt++;
      sbuff_write_done_i <= (wr_cnt >= cur_count);
      sbuff_read_done_i  <= (rd_cnt >= cur_count);
    end
  end

  // Unit burst carries every element and a strided burst one
  always @(posedge clk) begin
    if (!rstn) begin
      burst_active = 1'b0;
      burst_beats  = 0;
      ctrl_wdone_i <= 1'b0;
    end else begin
      ctrl_wdone_i <= 1'b0;
      if (ctrl_wstart_o) begin
        burst_active = 1'b1;
        burst_beats  = 0;
      end
      if (burst_active && wr_tvalid_o && wr_tready_i) begin
        burst_beats++;
        if (burst_beats == (cur_mode[1] ? cur_count : 1)) begin
          burst_active = 1'b0;
          ctrl_wdone_i <= 1'b1;
        end
      end
    end
  end

  // Beat and burst monitor with the element address at each burst start
  always @(posedge clk) begin
    if (cfg_update_o) begin
      beat_cnt   = 0;
      wstart_cnt = 0;
    end else begin
      if (wr_tvalid_o && wr_tready_i) beat_cnt++;
      if (ctrl_wstart_o) begin
        exp_addr = cur_mode[1] ? cur_base
                 : cur_base + cur_stride * mcu_pkg::addr_t'(wstart_cnt);
        check_addr(store_addr_o, exp_addr, "address at burst start");
        wstart_cnt++;
      end
    end
  end

  // Read stall follows back-pressure once the buffer has been filled
  always @(posedge clk) begin
    if (!rstn) begin
      in_drain = 1'b0;
    end else begin
      check_flag(sbuff_read_stall, in_drain && !st_rdy_o && !wr_tready_i, "read stall");
      in_drain = !st_rdy_o && sbuff_write_done_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Command sequence
  ////////////////////////////////////////////////////////////

  task automatic run_cmd(input int idx);
    int   b;
    int   cyc;
    logic exp_err;
    b       = idx * FIELDS;
    exp_err = cmd_mem[b+7][0];
    @(posedge clk);
    sew_i        <= cmd_mem[b][2:0];
    lmul_i       <= cmd_mem[b+1][2:0];
    data_width_i <= cmd_mem[b+2][2:0];
    mode_i       <= cmd_mem[b+3][1:0];
    base_addr_i  <= cmd_mem[b+4];
    stride_i     <= cmd_mem[b+5];
    st_vld_i     <= 1'b1;
    cur_mode   = cmd_mem[b+3][1:0];
    cur_base   = cmd_mem[b+4];
    cur_stride = cmd_mem[b+5];
    cur_count  = int'(cmd_mem[b+6]);
    @(posedge clk);
    st_vld_i <= 1'b0;
    @(negedge clk);
    if (cfg_update_o || cmd_err_o) begin
      $display("command %0d answered one cycle early", idx);
      abort_run();
    end
    @(negedge clk);
    check_flag(cmd_err_o, exp_err, "command error");
    check_flag(cfg_update_o, !exp_err, "config update");
    if (!exp_err) begin
      check_vtype(cfg_data_sew_o, cmd_mem[b+8][2:0], "data sew");
      check_vtype(cfg_data_lmul_o, cmd_mem[b+9][2:0], "data lmul");
      @(negedge clk);
      check_flag(st_rdy_o, 1'b0, "ready during store");
      cyc = 0;
      while (!st_rdy_o) begin
        @(negedge clk);
        cyc++;
        if (cyc > 400) begin
          $display("store %0d did not complete within 400 cycles", idx);
          abort_run();
        end
      end
      check_count(beat_cnt, cur_count, "accepted beats");
      check_count(wstart_cnt, cur_mode[1] ? 1 : cur_count, "write bursts");
    end else begin
      // Rejected command must leave the unit idle
      repeat (10) begin
        @(negedge clk);
        check_flag(st_rdy_o, 1'b1, "ready after error");
        check_flag(sbuff_wen_o, 1'b0, "buffer write after error");
      end
    end
  endtask

  initial begin
    rstn         = 1'b0;
    st_vld_i     = 1'b0;
    sew_i        = '0;
    lmul_i       = '0;
    data_width_i = '0;
    mode_i       = '0;
    base_addr_i  = '0;
    stride_i     = '0;
    $readmemh("test/mcu_store_input.txt", cmd_mem);
    while (n_cmds < MAX_CMDS && cmd_mem[n_cmds*FIELDS+6] != 32'd0) n_cmds++;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_flag(st_rdy_o, 1'b1, "ready after reset");
    check_flag(cfg_update_o, 1'b0, "config update after reset");
    check_flag(sbuff_wen_o | sbuff_ren_o, 1'b0, "buffer strobes after reset");
    check_flag(ctrl_wstart_o | wr_tvalid_o, 1'b0, "write channel after reset");
    check_addr(store_addr_o, '0, "address after reset");
    for (int i = 0; i < n_cmds; i++) begin
      run_cmd(i);
    end
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run();
    end
  end

  // Watchdog sized from the number of commands
  initial begin
    wait (n_cmds > 0);
    repeat (n_cmds * 400 + 16) @(posedge clk);
    $display("timeout after %0d commands worth of cycles", n_cmds);
    abort_run();
  end

endmodule

`default_nettype wire

/* verilog/mcu_cmd_decode.sv */
// Store command decode
// Registers the scheduler command, checks EMUL and latches the configuration

`timescale 1ns/1ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_cmd_decode (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 st_vld_i,
  input  mcu_pkg::vtype_t      sew_i,
  input  mcu_pkg::vtype_t      lmul_i,
  input  mcu_pkg::vtype_t      data_width_i,
  input  mcu_pkg::st_mode_t    mode_i,
  input  mcu_pkg::addr_t       base_addr_i,
  input  mcu_pkg::addr_t       stride_i,
  output logic                 cmd_err_o,
  mcu_store_cfg_if.decode      cfg
);

  logic                            st_vld_q;
  mcu_pkg::vtype_t                 sew_q;
  mcu_pkg::vtype_t                 lmul_q;
  mcu_pkg::vtype_t                 dw_q;
  mcu_pkg::st_mode_t               mode_q;
  mcu_pkg::addr_t                  base_q;
  mcu_pkg::addr_t                  stride_q;
  logic signed [`MCU_VTYPE_W+1:0]  emul_s;
  logic                            emul_ok;
  logic                            accept;

  ////////////////////////////////////////////////////////////
  // Command capture
  ////////////////////////////////////////////////////////////

  // Commands are taken only while the unit reports ready
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      st_vld_q <= 1'b0;
    end else begin
      st_vld_q <= st_vld_i && !cfg.busy;
    end
  end

  always_ff @(posedge clk) begin
    if (st_vld_i && !cfg.busy) begin
      sew_q    <= sew_i;
      lmul_q   <= lmul_i;
      dw_q     <= data_width_i;
      mode_q   <= mode_i;
      base_q   <= base_addr_i;
      stride_q <= stride_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // EMUL from lmul plus data width minus sew in log2
  ////////////////////////////////////////////////////////////

  // Lmul code is already a 3 bit two's complement value
  assign emul_s = $signed({{2{lmul_q[`MCU_VTYPE_W-1]}}, lmul_q})
                + $signed({2'b00, dw_q})
                - $signed({2'b00, sew_q});

  assign emul_ok = (sew_q < 'd3) && (lmul_q != 'd4) && (emul_s >= -3) && (emul_s <= 3);

  // A second command can not overtake a start still in flight
  assign accept = st_vld_q && emul_ok && !cfg.busy && !cfg.start;

  ////////////////////////////////////////////////////////////
  // Pulses and latched configuration
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg.start      <= 1'b0;
      cfg.cfg_update <= 1'b0;
      cmd_err_o      <= 1'b0;
      cfg.mode       <= '0;
      cfg.data_sew   <= '0;
      cfg.data_lmul  <= '0;
    end else begin
      cfg.start      <= accept;
      cfg.cfg_update <= accept;
      cmd_err_o      <= st_vld_q && !accept;
      if (accept) begin
        cfg.mode      <= mode_q;
        cfg.data_sew  <= dw_q;
        // Negative EMUL stored as 8 plus the value
        cfg.data_lmul <= emul_s[`MCU_VTYPE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cfg.base_addr <= base_q;
      cfg.stride    <= stride_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Sequencer must be idle whenever a store is started
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    cfg.start |-> !cfg.busy);

endmodule

`default_nettype wire

/* verilog/mcu_pkg.sv */
// Store memory control unit types
// Vector widths and the store sequencer state encoding

`default_nettype none

`include "mcu_settings.svh"

package mcu_pkg;

  // Byte address or stride
  typedef logic [`MCU_ADDR_W-1:0] addr_t;

  // Log2 width or multiplier code
  // Multiplier codes 5..7 are 1/8, 1/4, 1/2 and code 4 is reserved
  typedef logic [`MCU_VTYPE_W-1:0] vtype_t;

  // Mode flags with unit in bit 1 and strided in bit 0
  typedef logic [1:0] st_mode_t;

  typedef enum logic [2:0] {
    st_idle,
    st_fill,
    st_unit_tx,
    st_strided_prep,
    st_strided_tx
  } store_state_e;

endpackage

`default_nettype wire

/* verilog/mcu_settings.svh */
// Store memory control unit settings
// Widths of addresses and vector type codes, and write pipeline depth

`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Address path
////////////////////////////////////////////////////////////

// Byte address and stride width
`define MCU_ADDR_W 32

////////////////////////////////////////////////////////////
// Vector type codes and write stream
////////////////////////////////////////////////////////////

// Log2 codes for sew, lmul and memory data width
`define MCU_VTYPE_W 3
// Cycles from buffer read strobe to write valid
`define MCU_WR_DELAY 2

`endif

/* verilog/mcu_store_cfg_if.sv */
// Latched store configuration
// Passes the accepted command from decode to the store sequencer

`timescale 1ns/1ps
`default_nettype none

interface mcu_store_cfg_if;

  logic                 cfg_update;
  logic                 start;
  mcu_pkg::st_mode_t    mode;
  mcu_pkg::vtype_t      data_sew;
  mcu_pkg::vtype_t      data_lmul;
  mcu_pkg::addr_t       base_addr;
  mcu_pkg::addr_t       stride;
  // High from the first cycle after start until the store is done
  logic                 busy;

  modport decode (
    output cfg_update, start, mode, data_sew, data_lmul, base_addr, stride,
    input  busy
  );

  modport seq (
    input  cfg_update, start, mode, data_sew, data_lmul, base_addr, stride,
    output busy
  );

endinterface

`default_nettype wire

/* verilog/mcu_store_seq.sv */
// Store sequencer
// Fills the store buffer from the lane, then drains it as unit or strided bursts

`timescale 1ns/1ps
`default_nettype none

module mcu_store_seq (
  input  logic             clk,
  input  logic             rstn,
  input  logic             vlane_store_valid_i,
  input  logic             sbuff_write_done_i,
  input  logic             sbuff_read_done_i,
  input  logic             wr_tready_i,
  input  logic             ctrl_wdone_i,
  input  logic             pipe_empty_i,
  output logic             sbuff_wen_o,
  output logic             sbuff_ren_o,
  output logic             read_stall_o,
  output logic             read_invalidate_o,
  output logic             ctrl_wstart_o,
  output logic             addr_set_o,
  output logic             addr_update_o,
  mcu_store_cfg_if.seq     cfg
);

  mcu_pkg::store_state_e  state_q;
  mcu_pkg::store_state_e  state_d;
  // Write done of a unit burst may come before the pipe drains
  logic                   wdone_seen_q;

  ////////////////////////////////////////////////////////////
  // State and write-done tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= mcu_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wdone_seen_q <= 1'b0;
    end else if (state_q == mcu_pkg::st_idle) begin
      wdone_seen_q <= 1'b0;
    end else if (ctrl_wdone_i) begin
      wdone_seen_q <= 1'b1;
    end
  end

  assign cfg.busy = (state_q != mcu_pkg::st_idle);

  ////////////////////////////////////////////////////////////
  // Next state and control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    sbuff_wen_o       = 1'b0;
    sbuff_ren_o       = 1'b0;
    read_stall_o      = 1'b0;
    read_invalidate_o = 1'b0;
    ctrl_wstart_o     = 1'b0;
    addr_set_o        = 1'b0;
    addr_update_o     = 1'b0;

    case (state_q)
      mcu_pkg::st_idle: begin
        // Address register takes the base with the config update
        if (cfg.start) begin
          addr_set_o = 1'b1;
          state_d    = mcu_pkg::st_fill;
        end
      end

      mcu_pkg::st_fill: begin
        sbuff_wen_o = vlane_store_valid_i;
        if (sbuff_write_done_i) begin
          sbuff_wen_o = 1'b0;
          if (cfg.mode[1]) begin
            ctrl_wstart_o = 1'b1;
            state_d       = mcu_pkg::st_unit_tx;
          end else begin
            state_d = mcu_pkg::st_strided_prep;
          end
        end
      end

      // One burst for the whole buffer
      mcu_pkg::st_unit_tx: begin
        read_stall_o      = !wr_tready_i;
        read_invalidate_o = !wr_tready_i;
        sbuff_ren_o       = wr_tready_i && !sbuff_read_done_i;
        if (sbuff_read_done_i && pipe_empty_i && (wdone_seen_q || ctrl_wdone_i)) begin
          state_d = mcu_pkg::st_idle;
        end
      end

      // Read one element and open its single-beat burst
      mcu_pkg::st_strided_prep: begin
        read_stall_o      = !wr_tready_i;
        read_invalidate_o = !wr_tready_i;
        if (wr_tready_i) begin
          sbuff_ren_o   = 1'b1;
          ctrl_wstart_o = 1'b1;
          state_d       = mcu_pkg::st_strided_tx;
        end
      end

      mcu_pkg::st_strided_tx: begin
        read_stall_o      = !wr_tready_i;
        read_invalidate_o = !wr_tready_i;
        if (ctrl_wdone_i) begin
          addr_update_o = 1'b1;
          if (sbuff_read_done_i && pipe_empty_i) begin
            state_d = mcu_pkg::st_idle;
          end else begin
            state_d = mcu_pkg::st_strided_prep;
          end
        end
      end

      default: begin
        state_d = mcu_pkg::st_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/mcu_store_top.sv */
// Vector store memory control unit
// Command decode, store sequencer and write stream behind plain ports

`timescale 1ns/1ps
`default_nettype none

module mcu_store_top (
  input  logic               clk,
  input  logic               rstn,
  // Scheduler command
  input  logic               st_vld_i,
  output logic               st_rdy_o,
  input  mcu_pkg::vtype_t    sew_i,
  input  mcu_pkg::vtype_t    lmul_i,
  input  mcu_pkg::vtype_t    data_width_i,
  input  mcu_pkg::st_mode_t  mode_i,
  input  mcu_pkg::addr_t     base_addr_i,
  input  mcu_pkg::addr_t     stride_i,
  output logic               cmd_err_o,
  // Configuration toward the buffer array
  output logic               cfg_update_o,
  output mcu_pkg::vtype_t    cfg_data_sew_o,
  output mcu_pkg::vtype_t    cfg_data_lmul_o,
  // Store buffer and vector lane
  input  logic               vlane_store_valid_i,
  output logic               sbuff_wen_o,
  output logic               sbuff_ren_o,
  output logic               sbuff_read_stall_o,
  input  logic               sbuff_write_done_i,
  input  logic               sbuff_read_done_i,
  // Memory master write channel
  output logic               ctrl_wstart_o,
  input  logic               ctrl_wdone_i,
  output logic               wr_tvalid_o,
  input  logic               wr_tready_i,
  output mcu_pkg::addr_t     store_addr_o
);

  mcu_store_cfg_if  cfg ();

  logic  pipe_empty;
  logic  read_invalidate;
  logic  addr_set;
  logic  addr_update;

  assign st_rdy_o        = !cfg.busy;
  assign cfg_update_o    = cfg.cfg_update;
  assign cfg_data_sew_o  = cfg.data_sew;
  assign cfg_data_lmul_o = cfg.data_lmul;

  mcu_cmd_decode mcu_cmd_decode_inst (
    .clk          (clk),
    .rstn         (rstn),
    .st_vld_i     (st_vld_i),
    .sew_i        (sew_i),
    .lmul_i       (lmul_i),
    .data_width_i (data_width_i),
    .mode_i       (mode_i),
    .base_addr_i  (base_addr_i),
    .stride_i     (stride_i),
    .cmd_err_o    (cmd_err_o),
    .cfg          (cfg.decode)
  );

  mcu_store_seq mcu_store_seq_inst (
    .clk                 (clk),
    .rstn                (rstn),
    .vlane_store_valid_i (vlane_store_valid_i),
    .sbuff_write_done_i  (sbuff_write_done_i),
    .sbuff_read_done_i   (sbuff_read_done_i),
    .wr_tready_i         (wr_tready_i),
    .ctrl_wdone_i        (ctrl_wdone_i),
    .pipe_empty_i        (pipe_empty),
    .sbuff_wen_o         (sbuff_wen_o),
    .sbuff_ren_o         (sbuff_ren_o),
    .read_stall_o        (sbuff_read_stall_o),
    .read_invalidate_o   (read_invalidate),
    .ctrl_wstart_o       (ctrl_wstart_o),
    .addr_set_o          (addr_set),
    .addr_update_o       (addr_update),
    .cfg                 (cfg.seq)
  );

  mcu_wr_stream mcu_wr_stream_inst (
    .clk           (clk),
    .rstn          (rstn),
    .rd_strobe_i   (sbuff_ren_o),
    .stall_i       (sbuff_read_stall_o),
    .invalidate_i  (read_invalidate),
    .addr_set_i    (addr_set),
    .addr_update_i (addr_update),
    .base_addr_i   (cfg.base_addr),
    .stride_i      (cfg.stride),
    .wr_tvalid_o   (wr_tvalid_o),
    .pipe_empty_o  (pipe_empty),
    .store_addr_o  (store_addr_o)
  );

endmodule

`default_nettype wire

/* verilog/mcu_wr_stream.sv */
// Write stream output stage
// Read-to-valid delay line with stall and mask, plus the element address register

`timescale 1ns/1ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_wr_stream (
  input  logic            clk,
  input  logic            rstn,
  input  logic            rd_strobe_i,
  input  logic            stall_i,
  input  logic            invalidate_i,
  input  logic            addr_set_i,
  input  logic            addr_update_i,
  input  mcu_pkg::addr_t  base_addr_i,
  input  mcu_pkg::addr_t  stride_i,
  output logic            wr_tvalid_o,
  output logic            pipe_empty_o,
  output mcu_pkg::addr_t  store_addr_o
);

  // Bit n set means a read strobe is n+1 cycles old
  logic [`MCU_WR_DELAY-1:0]  vld_q;
  mcu_pkg::addr_t            addr_q;

  ////////////////////////////////////////////////////////////
  // Valid delay line
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_q <= '0;
    end else if (!stall_i) begin
      vld_q <= (vld_q << 1) | `MCU_WR_DELAY'(rd_strobe_i);
    end
  end

  assign wr_tvalid_o  = vld_q[`MCU_WR_DELAY-1] && !invalidate_i;
  assign pipe_empty_o = ~|vld_q;

  ////////////////////////////////////////////////////////////
  // Element address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      addr_q <= '0;
    end else if (addr_set_i) begin
      addr_q <= base_addr_i;
    end else if (addr_update_i) begin
      addr_q <= addr_q + stride_i;
    end
  end

  assign store_addr_o = addr_q;

  // Masked beat stays at the output stage until it can go out
  a_masked_beat_held: assert property (@(posedge clk) disable iff (!rstn)
    (invalidate_i && vld_q[`MCU_WR_DELAY-1]) |=> vld_q[`MCU_WR_DELAY-1]);

endmodule

`default_nettype wire
